/* verilog/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

    localparam int XLEN      = 16;
    localparam int NREG      = 8;
    localparam int REG_W     = 3;
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;
    localparam int INSN_W    = 16;

    // bit 3 set means the immediate form
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_MUL  = 4'h4,
        OP_ADDI = 4'h8
    } opcode_t;

    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_t;

    typedef struct packed {
        opcode_t          opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [2:0]       unused;
    } reg_fmt_t;

    typedef struct packed {
        opcode_t          opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic signed [5:0] imm;
    } imm_fmt_t;

    // same 16 bits, two views
    typedef union packed {
        reg_fmt_t reg_fmt;
        imm_fmt_t imm_fmt;
    } insn_t;

    // value valid when ready, tag valid otherwise
    typedef struct packed {
        logic             ready;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        opcode_t          opcode;
        logic [TAG_W-1:0] dest;
        operand_t         a;
        operand_t         b;
    } rs_entry_t;

endpackage

`default_nettype wire

/* verilog/dispatch_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

// dispatcher to one reservation station
interface rs_write_if;
    import dispatch_pkg::*;

    logic      valid;
    rs_entry_t entry;

    modport dispatcher (output valid, output entry);
    modport station    (input valid, input entry);
endinterface

// station to execution unit, fires on req and grant
interface issue_if;
    import dispatch_pkg::*;

    logic             req;
    logic             grant;
    opcode_t          opcode;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [TAG_W-1:0] tag;

    modport station (
        output req, output opcode, output a, output b, output tag,
        input  grant
    );
    modport unit (
        input  req, input opcode, input a, input b, input tag,
        output grant
    );
endinterface

`default_nettype wire

/* verilog/reg_rename.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_rename (
    input  logic                                                    clk,
    input  logic                                                    arst_n,
    input  logic                                                    rename_en,
    input  logic [dispatch_pkg::REG_W-1:0]                          rename_rd,
    input  logic [dispatch_pkg::TAG_W-1:0]                          rename_tag,
    input  logic                                                    commit_valid,
    input  logic [dispatch_pkg::REG_W-1:0]                          commit_rd,
    input  logic [dispatch_pkg::TAG_W-1:0]                          commit_tag,
    input  logic [dispatch_pkg::XLEN-1:0]                           commit_value,
    output logic [dispatch_pkg::NREG-1:0][dispatch_pkg::XLEN-1:0]  reg_value,
    output logic [dispatch_pkg::NREG-1:0]                           reg_busy,
    output logic [dispatch_pkg::NREG-1:0][dispatch_pkg::TAG_W-1:0] reg_tag
);
    import dispatch_pkg::*;

    logic tag_match;

    // only the youngest writer of a register may retire its rename
    assign tag_match = reg_busy[commit_rd] && (reg_tag[commit_rd] == commit_tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_value <= '0;
            reg_busy  <= '0;
            reg_tag   <= '0;
        end else begin
            if (commit_valid && tag_match) begin
                reg_value[commit_rd] <= commit_value;
                reg_busy[commit_rd]  <= 1'b0;
            end
            // new rename overrides a same-cycle commit
            if (rename_en) begin
                reg_busy[rename_rd] <= 1'b1;
                reg_tag[rename_rd]  <= rename_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
    input  logic                                                         clk,
    input  logic                                                         arst_n,
    input  logic                                                         alloc,
    input  logic [dispatch_pkg::REG_W-1:0]                               alloc_rd,
    output logic [dispatch_pkg::TAG_W-1:0]                               alloc_tag,
    output logic                                                         rob_full,
    input  logic                                                         cdb_valid,
    input  logic [dispatch_pkg::TAG_W-1:0]                               cdb_tag,
    input  logic [dispatch_pkg::XLEN-1:0]                                cdb_value,
    output logic [dispatch_pkg::ROB_DEPTH-1:0]                           rob_done,
    output logic [dispatch_pkg::ROB_DEPTH-1:0][dispatch_pkg::XLEN-1:0]  rob_value,
    output logic                                                         commit_valid,
    output logic [dispatch_pkg::REG_W-1:0]                               commit_rd,
    output logic [dispatch_pkg::TAG_W-1:0]                               commit_tag,
    output logic [dispatch_pkg::XLEN-1:0]                                commit_value
);
    import dispatch_pkg::*;

    logic [TAG_W-1:0]                head;
    logic [TAG_W-1:0]                tail;
    logic [TAG_W:0]                  count;
    logic [ROB_DEPTH-1:0][REG_W-1:0] rd_q;
    logic                            do_commit;

    assign alloc_tag = tail;
    assign rob_full  = (count == (TAG_W+1)'(ROB_DEPTH));
    // done bits stay set after commit, so the count guards the head
    assign do_commit = (count != '0) && rob_done[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            rob_done     <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= do_commit;
            if (alloc) begin
                rob_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (cdb_valid) begin
                rob_done[cdb_tag] <= 1'b1;
            end
            if (do_commit) begin
                head <= head + 1'b1;
            end
            case ({alloc, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (cdb_valid) begin
            rob_value[cdb_tag] <= cdb_value;
        end
        if (do_commit) begin
            commit_rd    <= rd_q[head];
            commit_tag   <= head;
            commit_value <= rob_value[head];
        end
    end

endmodule

`default_nettype wire

/* verilog/reservation_station.sv */
`timescale 1ns/1ns
`default_nettype none

module reservation_station #(
    parameter int RS_DEPTH = 2
) (
    input  logic                           clk,
    input  logic                           arst_n,
    rs_write_if.station                    wr,
    input  logic                           cdb_valid,
    input  logic [dispatch_pkg::TAG_W-1:0] cdb_tag,
    input  logic [dispatch_pkg::XLEN-1:0]  cdb_value,
    issue_if.station                       iss,
    output logic                           credit
);
    import dispatch_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    rs_entry_t [RS_DEPTH-1:0] slot;
    logic [RS_DEPTH-1:0]      used;
    logic [IDX_W-1:0]         free_idx;
    logic [IDX_W-1:0]         iss_idx;
    logic                     any_rdy;
    logic                     fire;

    // lowest free slot and lowest ready slot, scanned downward
    always_comb begin
        free_idx = '0;
        iss_idx  = '0;
        any_rdy  = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_idx = IDX_W'(i);
            end
            if (used[i] && slot[i].a.ready && slot[i].b.ready) begin
                iss_idx = IDX_W'(i);
                any_rdy = 1'b1;
            end
        end
    end

    assign iss.req    = any_rdy;
    assign iss.opcode = slot[iss_idx].opcode;
    assign iss.a      = slot[iss_idx].a.value;
    assign iss.b      = slot[iss_idx].b.value;
    assign iss.tag    = slot[iss_idx].dest;
    assign fire       = iss.req && iss.grant;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            used   <= '0;
            credit <= 1'b0;
        end else begin
            credit <= fire;
            if (fire) begin
                used[iss_idx] <= 1'b0;
            end
            if (wr.valid) begin
                used[free_idx] <= 1'b1;
            end
        end
    end

    // wakeup of waiting operands from the CDB
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid && !slot[i].a.ready && (slot[i].a.tag == cdb_tag)) begin
                slot[i].a.ready <= 1'b1;
                slot[i].a.value <= cdb_value;
            end
            if (cdb_valid && !slot[i].b.ready && (slot[i].b.tag == cdb_tag)) begin
                slot[i].b.ready <= 1'b1;
                slot[i].b.value <= cdb_value;
            end
        end
        if (wr.valid) begin
            slot[free_idx] <= wr.entry;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_cluster.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_cluster (
    input  logic                           clk,
    input  logic                           arst_n,
    issue_if.unit                          alu_iss,
    issue_if.unit                          mul_iss,
    output logic                           cdb_valid,
    output logic [dispatch_pkg::TAG_W-1:0] cdb_tag,
    output logic [dispatch_pkg::XLEN-1:0]  cdb_value
);
    import dispatch_pkg::*;

    opcode_t          sel_op;
    logic [XLEN-1:0]  sel_a;
    logic [XLEN-1:0]  sel_b;
    logic [TAG_W-1:0] sel_tag;
    logic [XLEN-1:0]  result;
    logic             mul_fire;

    // fixed priority, ALU first
    assign alu_iss.grant = 1'b1;
    assign mul_iss.grant = !alu_iss.req;
    assign mul_fire      = mul_iss.req && mul_iss.grant;

    always_comb begin
        if (alu_iss.req) begin
            sel_op  = alu_iss.opcode;
            sel_a   = alu_iss.a;
            sel_b   = alu_iss.b;
            sel_tag = alu_iss.tag;
        end else begin
            sel_op  = mul_iss.opcode;
            sel_a   = mul_iss.a;
            sel_b   = mul_iss.b;
            sel_tag = mul_iss.tag;
        end
        case (sel_op)
            OP_SUB:  result = sel_a - sel_b;
            OP_AND:  result = sel_a & sel_b;
            OP_XOR:  result = sel_a ^ sel_b;
            // low half of the product only
            OP_MUL:  result = sel_a * sel_b;
            default: result = sel_a + sel_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_iss.req || mul_fire;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag   <= sel_tag;
        cdb_value <= result;
    end

endmodule

`default_nettype wire

/* verilog/dispatcher.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatcher #(
    parameter int RS_DEPTH = 2
) (
    input  logic                                                         clk,
    input  logic                                                         arst_n,
    input  logic                                                         insn_valid,
    input  dispatch_pkg::insn_t                                          insn,
    output logic                                                         insn_ready,
    input  logic                                                         rob_full,
    input  logic [dispatch_pkg::TAG_W-1:0]                               alloc_tag,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0]                           rob_done,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0][dispatch_pkg::XLEN-1:0]  rob_value,
    output logic                                                         alloc,
    output logic [dispatch_pkg::REG_W-1:0]                               alloc_rd,
    input  logic [dispatch_pkg::NREG-1:0][dispatch_pkg::XLEN-1:0]       reg_value,
    input  logic [dispatch_pkg::NREG-1:0]                                reg_busy,
    input  logic [dispatch_pkg::NREG-1:0][dispatch_pkg::TAG_W-1:0]      reg_tag,
    output logic                                                         rename_en,
    output logic [dispatch_pkg::REG_W-1:0]                               rename_rd,
    output logic [dispatch_pkg::TAG_W-1:0]                               rename_tag,
    input  logic                                                         cdb_valid,
    input  logic [dispatch_pkg::TAG_W-1:0]                               cdb_tag,
    input  logic [dispatch_pkg::XLEN-1:0]                                cdb_value,
    input  logic                                                         credit_alu,
    input  logic                                                         credit_mul,
    rs_write_if.dispatcher                                               alu_wr,
    rs_write_if.dispatcher                                               mul_wr
);
    import dispatch_pkg::*;

    localparam int CRED_W = $clog2(RS_DEPTH + 1);

    opcode_t               op;
    fu_t                   fu;
    logic [XLEN-1:0]       imm_ext;
    operand_t              src_a;
    operand_t              src_b;
    logic                  accept;
    logic [1:0]            wr_sel;
    logic [1:0]            ret;
    logic [1:0][CRED_W-1:0] credits;

    // register file, then CDB, then ROB, otherwise wait on the tag
    function automatic operand_t lookup(input logic [REG_W-1:0] r);
        operand_t opnd;
        opnd.tag   = reg_tag[r];
        opnd.ready = 1'b1;
        if (!reg_busy[r]) begin
            opnd.value = reg_value[r];
        end else if (cdb_valid && (cdb_tag == reg_tag[r])) begin
            opnd.value = cdb_value;
        end else if (rob_done[reg_tag[r]]) begin
            opnd.value = rob_value[reg_tag[r]];
        end else begin
            opnd.ready = 1'b0;
            opnd.value = '0;
        end
        return opnd;
    endfunction

    assign op      = insn.reg_fmt.opcode;
    assign fu      = (op == OP_MUL) ? FU_MUL : FU_ALU;
    assign imm_ext = {{(XLEN-6){insn.imm_fmt.imm[5]}}, insn.imm_fmt.imm};

    always_comb begin
        src_a = lookup(insn.reg_fmt.rs1);
        if (op[3]) begin
            src_b = '{ready: 1'b1, tag: '0, value: imm_ext};
        end else begin
            src_b = lookup(insn.reg_fmt.rs2);
        end
    end

    // stall on a full ROB or an empty credit counter
    assign insn_ready = !rob_full && (credits[fu] != '0);
    assign accept     = insn_valid && insn_ready;

    assign alloc      = accept;
    assign alloc_rd   = insn.reg_fmt.rd;
    assign rename_en  = accept;
    assign rename_rd  = insn.reg_fmt.rd;
    assign rename_tag = alloc_tag;

    assign wr_sel[FU_ALU] = accept && (fu == FU_ALU);
    assign wr_sel[FU_MUL] = accept && (fu == FU_MUL);
    assign ret[FU_ALU]    = credit_alu;
    assign ret[FU_MUL]    = credit_mul;

    assign alu_wr.valid = wr_sel[FU_ALU];
    assign alu_wr.entry = '{opcode: op, dest: alloc_tag, a: src_a, b: src_b};
    assign mul_wr.valid = wr_sel[FU_MUL];
    assign mul_wr.entry = '{opcode: op, dest: alloc_tag, a: src_a, b: src_b};

    // one write and one return may meet in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2; i++) begin
                credits[i] <= CRED_W'(RS_DEPTH);
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                credits[i] <= credits[i] + CRED_W'(ret[i]) - CRED_W'(wr_sel[i]);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dispatch_core.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch_core #(
    parameter int RS_DEPTH = 2
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            insn_valid,
    input  logic [dispatch_pkg::INSN_W-1:0] insn,
    output logic                            insn_ready,
    output logic                            commit_valid,
    output logic [dispatch_pkg::REG_W-1:0]  commit_rd,
    output logic [dispatch_pkg::XLEN-1:0]   commit_value
);
    import dispatch_pkg::*;

    logic                            alloc;
    logic [REG_W-1:0]                alloc_rd;
    logic [TAG_W-1:0]                alloc_tag;
    logic                            rob_full;
    logic [ROB_DEPTH-1:0]            rob_done;
    logic [ROB_DEPTH-1:0][XLEN-1:0]  rob_value;
    logic [NREG-1:0][XLEN-1:0]       reg_value;
    logic [NREG-1:0]                 reg_busy;
    logic [NREG-1:0][TAG_W-1:0]      reg_tag;
    logic                            rename_en;
    logic [REG_W-1:0]                rename_rd;
    logic [TAG_W-1:0]                rename_tag;
    logic [TAG_W-1:0]                commit_tag;
    logic                            cdb_valid;
    logic [TAG_W-1:0]                cdb_tag;
    logic [XLEN-1:0]                 cdb_value;
    logic                            credit_alu;
    logic                            credit_mul;

    rs_write_if alu_wr ();
    rs_write_if mul_wr ();
    issue_if    alu_iss ();
    issue_if    mul_iss ();

    reg_rename rename0 (
        .clk, .arst_n, .rename_en, .rename_rd, .rename_tag,
        .commit_valid, .commit_rd, .commit_tag, .commit_value,
        .reg_value, .reg_busy, .reg_tag
    );

    reorder_buffer rob0 (
        .clk, .arst_n, .alloc, .alloc_rd, .alloc_tag, .rob_full,
        .cdb_valid, .cdb_tag, .cdb_value, .rob_done, .rob_value,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    dispatcher #(.RS_DEPTH(RS_DEPTH)) disp0 (
        .clk, .arst_n, .insn_valid, .insn(insn_t'(insn)), .insn_ready,
        .rob_full, .alloc_tag, .rob_done, .rob_value, .alloc, .alloc_rd,
        .reg_value, .reg_busy, .reg_tag, .rename_en, .rename_rd, .rename_tag,
        .cdb_valid, .cdb_tag, .cdb_value, .credit_alu, .credit_mul,
        .alu_wr(alu_wr.dispatcher), .mul_wr(mul_wr.dispatcher)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) rs_alu (
        .clk, .arst_n, .wr(alu_wr.station), .cdb_valid, .cdb_tag, .cdb_value,
        .iss(alu_iss.station), .credit(credit_alu)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) rs_mul (
        .clk, .arst_n, .wr(mul_wr.station), .cdb_valid, .cdb_tag, .cdb_value,
        .iss(mul_iss.station), .credit(credit_mul)
    );

    exec_cluster exec0 (
        .clk, .arst_n, .alu_iss(alu_iss.unit), .mul_iss(mul_iss.unit),
        .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/dispatch_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch_assertions #(
    parameter int RS_DEPTH = 2
) (
    input logic                                     clk,
    input logic                                     arst_n,
    input logic                                     insn_valid,
    input logic                                     insn_ready,
    input logic                                     alloc,
    input logic [1:0]                               wr_sel,
    input logic [1:0][$clog2(RS_DEPTH + 1)-1:0]     credits
);

    // index 0 is the ALU station, 1 the MUL station
    alu_write_needs_credit: assert property (
        @(posedge clk) disable iff (!arst_n) wr_sel[0] |-> (credits[0] != '0)
    ) else $error("ALU station written with no credit left");

    mul_write_needs_credit: assert property (
        @(posedge clk) disable iff (!arst_n) wr_sel[1] |-> (credits[1] != '0)
    ) else $error("MUL station written with no credit left");

    alloc_is_handshake: assert property (
        @(posedge clk) disable iff (!arst_n) alloc == (insn_valid && insn_ready)
    ) else $error("ROB allocation does not match the input handshake");

    credits_bounded: assert property (
        @(posedge clk) disable iff (!arst_n)
        (credits[0] <= RS_DEPTH) && (credits[1] <= RS_DEPTH)
    ) else $error("credit counter above station depth");

endmodule

bind dispatcher dispatch_assertions #(.RS_DEPTH(RS_DEPTH)) chk0 (
    .clk, .arst_n, .insn_valid, .insn_ready, .alloc, .wr_sel, .credits
);

`default_nettype wire

/* bench/dispatch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch_tb;
    import dispatch_pkg::*;

    localparam int N_T1  = 8;
    localparam int N_T2  = 16;
    localparam int N_T3  = 24;
    localparam int N_T4  = 20;
    localparam int N_T5  = 200;
    localparam int LIMIT = 64 * (N_T1 + N_T2 + N_T3 + N_T4 + N_T5) + 200;

    logic        clk;
    logic        arst_n;
    logic        insn_valid;
    logic [15:0] insn;
    logic        insn_ready;
    logic        commit_valid;
    logic [2:0]  commit_rd;
    logic [15:0] commit_value;

    logic [15:0] model_regs [8];
    logic [2:0]  exp_rd_q [$];
    logic [15:0] exp_val_q [$];
    logic [2:0]  exp_rd;
    logic [15:0] exp_val;
    logic [16:0] lfsr;
    int          errors;
    int          accepted;
    int          commits;
    int          stalls;
    int          cycles;
    int          tests;

    clock_gen clk0 (.clk, .arst_n);

    // three entries let the ALU station take one instruction every cycle
    dispatch_core #(.RS_DEPTH(3)) dut0 (
        .clk, .arst_n, .insn_valid, .insn, .insn_ready,
        .commit_valid, .commit_rd, .commit_value
    );

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    function automatic logic [3:0] op_at(input int idx);
        case (idx)
            0: return OP_ADD;
            1: return OP_SUB;
            2: return OP_AND;
            3: return OP_XOR;
            4: return OP_MUL;
            default: return OP_ADDI;
        endcase
    endfunction

    // low6 is {rs2, 3'b0} in register form, the imm otherwise
    function automatic logic [15:0] make_insn(input logic [3:0] op, input int rd,
                                              input int rs1, input logic [5:0] low6);
        return {op, rd[2:0], rs1[2:0], low6};
    endfunction

    function automatic logic [15:0] ref_exec(input logic [15:0] w);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        a = model_regs[w[8:6]];
        b = model_regs[w[5:3]];
        case (w[15:12])
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_XOR:  r = a ^ b;
            OP_MUL:  r = a * b;
            default: r = a + {{10{w[5]}}, w[5:0]};
        endcase
        return r;
    endfunction

    // entered and left 1 ns after a rising edge
    task automatic send_insn(input logic [15:0] w, input int gap);
        logic taken;
        insn_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        insn_valid = 1'b1;
        insn       = w;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = insn_ready;
            if (!taken) begin
                stalls++;
            end
            @(posedge clk);
            #1;
        end
        exp_rd_q.push_back(w[11:9]);
        exp_val_q.push_back(ref_exec(w));
        model_regs[w[11:9]] = ref_exec(w);
        accepted++;
        insn_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err0, input int stall0,
                               input bit need_stall);
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        tests++;
        assert (commits == accepted) else begin
            $display("commit count %0d differs from accepted count %0d", commits, accepted);
            errors++;
        end
        if (need_stall) begin
            assert (stalls > stall0) else begin
                $display("insn_ready never dropped during %s", name);
                errors++;
            end
        end
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == err0) ? "ok" : "mismatch", errors - err0);
    endtask

    // commit checker
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            commits++;
            if (exp_rd_q.size() == 0) begin
                $display("commit at %0t with no instruction outstanding", $time);
                errors++;
            end else begin
                exp_rd  = exp_rd_q.pop_front();
                exp_val = exp_val_q.pop_front();
                assert (commit_rd == exp_rd) else begin
                    $display("Error: time %0t, commit rd %0d, expected %0d",
                             $time, commit_rd, exp_rd);
                    errors++;
                end
                assert (commit_value == exp_val) else begin
                    $display("Error: time %0t, commit value %h for r%0d, expected %h",
                             $time, commit_value, exp_rd, exp_val);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        int          e0;
        int          s0;
        logic [15:0] r;
        logic [15:0] g;
        insn_valid = 1'b0;
        insn       = '0;
        lfsr       = 17'd92255;
        errors     = 0;
        accepted   = 0;
        commits    = 0;
        stalls     = 0;
        cycles     = 0;
        tests      = 0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;

        // independent ADDI, r0 written last
        e0 = errors;
        s0 = stalls;
        assert (!commit_valid && insn_ready) else begin
            $display("after reset commit_valid is high or insn_ready is low");
            errors++;
        end
        for (int i = 0; i < N_T1; i++) begin
            send_insn(make_insn(OP_ADDI, (i + 1) % 8, 0, 6'(i * 5 - 13)), 0);
        end
        finish_test("independent ADDI", e0, s0, 1'b0);

        // each result feeds the next two
        e0 = errors;
        s0 = stalls;
        for (int i = 0; i < N_T2; i++) begin
            r = op_at((i * 5) % 6);
            send_insn(make_insn(r[3:0], 1 + i % 3, 1 + (i + 2) % 3,
                                r[3] ? 6'(i - 8) : {3'(1 + (i + 1) % 3), 3'b000}), 0);
        end
        finish_test("dependent chains", e0, s0, 1'b0);

        // MUL chain with ALU work holding the CDB
        e0 = errors;
        s0 = stalls;
        for (int i = 0; i < N_T3; i++) begin
            if (i % 4 == 3) begin
                send_insn(make_insn(OP_ADD, 7, 7, {3'd1, 3'b000}), 0);
            end else begin
                send_insn(make_insn(OP_MUL, 4 + i % 2, 4 + (i + 1) % 2, {3'd2, 3'b000}), 0);
            end
        end
        finish_test("MUL credit burst", e0, s0, 1'b1);

        // MUL head waits on an ADDI, then a steady ALU stream keeps
        // the CDB busy so the head stays open until the ROB fills
        e0 = errors;
        s0 = stalls;
        send_insn(make_insn(OP_ADDI, 1, 0, 6'd3), 0);
        send_insn(make_insn(OP_MUL, 1, 1, {3'd3, 3'b000}), 0);
        for (int i = 0; i < N_T4 - 2; i++) begin
            send_insn(make_insn(OP_ADDI, 2 + i % 6, 0, 6'(i)), 0);
        end
        finish_test("ROB full", e0, s0, 1'b1);

        e0 = errors;
        s0 = stalls;
        for (int i = 0; i < N_T5; i++) begin
            take_bits(3, r);
            r[3:0] = op_at(r % 6);
            take_bits(12, g);
            r = {r[3:0], g[11:0]};
            if (!r[15]) begin
                r[2:0] = 3'b000;
            end
            take_bits(2, g);
            send_insn(r, g);
        end
        finish_test("random program", e0, s0, 1'b0);

        $display("tests %0d, accepted %0d, commits %0d, errors %0d",
                 tests, accepted, commits, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/dispatch_pkg.sv
verilog/dispatch_ifs.sv
verilog/reg_rename.sv
verilog/reorder_buffer.sv
verilog/reservation_station.sv
verilog/exec_cluster.sv
verilog/dispatcher.sv
verilog/dispatch_core.sv
bench/clock_gen.sv
bench/dispatch_assertions.sv
bench/dispatch_tb.sv
